/* Bender.yml */
package:
  name: mbox

export_include_dirs:
  - design

sources:
  - files:
      - design/mbox_pkg.sv
      - design/mbox_fsm.sv
      - design/mbox_regs.sv
      - design/mbox_ptrs.sv
      - design/mbox_mem.sv
      - design/mbox_top.sv
  - target: test
    files:
      - bench/mbox_tb.sv

/* bench/mbox_tb.sv */
// mailbox testbench with clock, reset, stimulus table, compare tasks, timeout and report
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_tb;
    import mbox_pkg::*;

    // one table row holds the request to drive and what the response must show
    typedef struct packed {
        logic [3:0] test;
        logic       wr;
        logic       soc;
        mbox_addr_t addr;
        mbox_data_t wdata;
        mbox_data_t exp;
        logic       exp_err;
        logic       is_status;
        logic       chk_notif;
        logic [2:0] notif;
    } entry_t;

    logic       clk;
    logic       rst_b;
    logic       req_valid;
    logic       req_write;
    logic       req_soc;
    mbox_addr_t req_addr;
    mbox_data_t req_wdata;
    logic       req_ready;
    logic       rsp_valid;
    logic       rsp_error;
    mbox_data_t rsp_rdata;
    logic       uc_data_avail;
    logic       soc_data_avail;
    logic       soc_req_lock;

    entry_t tbl[$];
    string  test_names[$];
    integer seed;
    int     cur_test;
    int     n_checks;
    int     n_errors;
    int     test_err_base;
    int     tests_failed;
    int     cycle_count;
    int     timeout_limit;

    mbox_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_data(input string name, input mbox_data_t got, input mbox_data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic check_state(input string name, input mbox_state_e got, input mbox_state_e exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic check_cmd_status(input string name, input mbox_cmd_status_e got,
                                    input mbox_cmd_status_e exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
            n_errors++;
        end
    endtask

    // state sits in bits 8:6 of status and the command status in the low nibble
    function automatic mbox_data_t status_word(input mbox_state_e st, input mbox_cmd_status_e cs);
        mbox_data_t w;
        w = '0;
        w[8:6] = st;
        w[3:0] = cs;
        return w;
    endfunction

    task automatic start_test(input string name);
        test_names.push_back(name);
        cur_test = test_names.size() - 1;
    endtask

    task automatic add_entry(input logic wr, input logic soc, input mbox_addr_t addr,
                             input mbox_data_t wdata, input mbox_data_t exp, input logic exp_err,
                             input logic is_status, input logic chk_notif,
                             input logic [2:0] notif);
        entry_t e;
        e.test      = cur_test[3:0];
        e.wr        = wr;
        e.soc       = soc;
        e.addr      = addr;
        e.wdata     = wdata;
        e.exp       = exp;
        e.exp_err   = exp_err;
        e.is_status = is_status;
        e.chk_notif = chk_notif;
        e.notif     = notif;
        tbl.push_back(e);
    endtask

    task automatic add_write(input logic soc, input mbox_addr_t addr, input mbox_data_t wdata);
        add_entry(1'b1, soc, addr, wdata, '0, 1'b0, 1'b0, 1'b0, 3'b000);
    endtask

    task automatic add_read(input logic soc, input mbox_addr_t addr, input mbox_data_t exp,
                            input logic exp_err);
        add_entry(1'b0, soc, addr, '0, exp, exp_err, 1'b0, 1'b0, 3'b000);
    endtask

    // notif is {uc_data_avail, soc_data_avail, soc_req_lock}
    task automatic add_status(input logic soc, input mbox_state_e st, input mbox_cmd_status_e cs,
                              input logic [2:0] notif);
        add_entry(1'b0, soc, `MBOX_STATUS_OFS, '0, status_word(st, cs), 1'b0, 1'b1, 1'b1, notif);
    endtask

    task automatic build_table();
        mbox_data_t msg [5];
        mbox_data_t rsp [2];
        mbox_data_t part [3];
        mbox_data_t extra;
        for (int i = 0; i < 5; i++) begin
            msg[i] = $random(seed);
        end
        for (int i = 0; i < 2; i++) begin
            rsp[i] = $random(seed);
        end
        for (int i = 0; i < 3; i++) begin
            part[i] = $random(seed);
        end
        extra = $random(seed);

        // the SoC takes the lock and a uC lock read asks it to let go
        start_test("lock acquire");
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd0, 1'b0);
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd1, 1'b0);
        add_entry(1'b0, 1'b0, `MBOX_LOCK_OFS, '0, 32'd1, 1'b0, 1'b0, 1'b1, 3'b001);
        add_status(1'b1, MBOX_RDY_FOR_CMD, CMD_BUSY, 3'b000);

        // the uC holds no lock here so its command write is dropped
        start_test("requester rules");
        add_write(1'b1, `MBOX_CMD_OFS, 32'hA5A5_0001);
        add_write(1'b0, `MBOX_CMD_OFS, 32'h5A5A_0002);
        add_read(1'b1, `MBOX_CMD_OFS, 32'hA5A5_0001, 1'b0);
        add_read(1'b1, 5'h01, 32'd0, 1'b1);
        add_status(1'b1, MBOX_RDY_FOR_DLEN, CMD_BUSY, 3'b000);

        start_test("message soc to uc");
        add_write(1'b1, `MBOX_DLEN_OFS, 32'd20);
        for (int i = 0; i < 5; i++) begin
            add_write(1'b1, `MBOX_DATAIN_OFS, msg[i]);
        end
        add_write(1'b1, `MBOX_EXECUTE_OFS, 32'd1);
        add_status(1'b1, MBOX_EXECUTE_UC, CMD_BUSY, 3'b100);
        for (int i = 0; i < 5; i++) begin
            add_read(1'b0, `MBOX_DATAOUT_OFS, msg[i], 1'b0);
        end

        // the owner cannot read its own message, and the receiver gets zero past the end
        start_test("receiver rules");
        add_read(1'b1, `MBOX_DATAOUT_OFS, 32'd0, 1'b1);
        add_read(1'b0, `MBOX_DATAOUT_OFS, 32'd0, 1'b0);

        start_test("turnaround and release");
        add_write(1'b0, `MBOX_DATAIN_OFS, rsp[0]);
        add_write(1'b0, `MBOX_DATAIN_OFS, rsp[1]);
        add_write(1'b0, `MBOX_STATUS_OFS, 32'(DATA_READY));
        add_status(1'b1, MBOX_EXECUTE_SOC, DATA_READY, 3'b010);
        add_read(1'b1, `MBOX_DATAOUT_OFS, rsp[0], 1'b0);
        add_read(1'b1, `MBOX_DATAOUT_OFS, rsp[1], 1'b0);
        add_read(1'b1, `MBOX_DATAOUT_OFS, 32'd0, 1'b0);
        add_write(1'b1, `MBOX_EXECUTE_OFS, 32'd0);
        add_status(1'b1, MBOX_IDLE, CMD_BUSY, 3'b000);
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd0, 1'b0);

        // eight words declared but only three written
        start_test("length truncation");
        add_write(1'b1, `MBOX_CMD_OFS, 32'h0000_00C3);
        add_write(1'b1, `MBOX_DLEN_OFS, 32'd32);
        for (int i = 0; i < 3; i++) begin
            add_write(1'b1, `MBOX_DATAIN_OFS, part[i]);
        end
        add_write(1'b1, `MBOX_EXECUTE_OFS, 32'd1);
        add_status(1'b0, MBOX_EXECUTE_UC, CMD_BUSY, 3'b100);
        for (int i = 0; i < 3; i++) begin
            add_read(1'b0, `MBOX_DATAOUT_OFS, part[i], 1'b0);
        end
        add_read(1'b0, `MBOX_DATAOUT_OFS, 32'd0, 1'b0);
        add_read(1'b0, `MBOX_DATAOUT_OFS, 32'd0, 1'b0);
        add_write(1'b1, `MBOX_EXECUTE_OFS, 32'd0);

        // the owner leaves a failure status behind so the unlock has something to clear
        start_test("force unlock");
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd0, 1'b0);
        add_write(1'b1, `MBOX_CMD_OFS, 32'h0000_0077);
        add_write(1'b1, `MBOX_DLEN_OFS, 32'd4);
        add_write(1'b1, `MBOX_DATAIN_OFS, extra);
        add_write(1'b1, `MBOX_STATUS_OFS, 32'(CMD_FAILURE));
        add_status(1'b0, MBOX_RDY_FOR_DATA, CMD_FAILURE, 3'b000);
        add_write(1'b0, `MBOX_UNLOCK_OFS, 32'd1);
        add_status(1'b1, MBOX_IDLE, CMD_BUSY, 3'b000);
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd0, 1'b0);
        add_read(1'b1, `MBOX_LOCK_OFS, 32'd1, 1'b0);
    endtask

    // runs at the falling edge after acceptance, where the response is stable
    task automatic check_entry(input entry_t e);
        // ready stays high after a write and drops for one cycle after a read
        check_bit("req_ready", req_ready, e.wr);
        if (e.wr) begin
            check_bit("rsp_valid", rsp_valid, 1'b0);
        end else begin
            check_bit("rsp_valid", rsp_valid, 1'b1);
            check_bit("rsp_error", rsp_error, e.exp_err);
            if (e.is_status) begin
                check_state("status state", mbox_state_e'(rsp_rdata[8:6]),
                            mbox_state_e'(e.exp[8:6]));
                check_cmd_status("status cmd_status", mbox_cmd_status_e'(rsp_rdata[3:0]),
                                 mbox_cmd_status_e'(e.exp[3:0]));
            end else begin
                check_data("rsp_rdata", rsp_rdata, e.exp);
            end
        end
        if (e.chk_notif) begin
            check_bit("uc_data_avail", uc_data_avail, e.notif[2]);
            check_bit("soc_data_avail", soc_data_avail, e.notif[1]);
            check_bit("soc_req_lock", soc_req_lock, e.notif[0]);
        end
    endtask

    task automatic report_test(input int id);
        if (n_errors == test_err_base) begin
            $display("test %0d %s: passed", id + 1, test_names[id]);
        end else begin
            $display("test %0d %s: failed with %0d mismatches", id + 1, test_names[id],
                     n_errors - test_err_base);
            tests_failed++;
        end
        test_err_base = n_errors;
    endtask

    // ends the run if the table stalls on the handshake
    initial begin
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the request table did not complete", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        entry_t e;
        rst_b         = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_soc       = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        seed          = 32'h9f96e4ef;
        n_checks      = 0;
        n_errors      = 0;
        test_err_base = 0;
        tests_failed  = 0;
        cycle_count   = 0;
        build_table();
        timeout_limit = tbl.size() * 8 + 100;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;

        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (i > 0 && e.test != tbl[i-1].test) begin
                report_test(tbl[i-1].test);
            end
            @(negedge clk);
            req_valid = 1'b1;
            req_write = e.wr;
            req_soc   = e.soc;
            req_addr  = e.addr;
            req_wdata = e.wdata;
            // ready only moves on the rising edge, so high here means accepted at the next one
            while (!req_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            req_valid = 1'b0;
            check_entry(e);
        end
        report_test(tbl[tbl.size()-1].test);

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches", test_names.size(),
                 tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* design/mbox_cfg.svh */
// mailbox data and length widths, array depth and register byte offsets
`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// one data word and the number of words in the array
`define MBOX_DATA_W 32
`define MBOX_DEPTH  64
`define MBOX_PTR_W  6

// register offsets are byte addresses inside an eight word window
`define MBOX_ADDR_W 5
`define MBOX_DLEN_W 16

`define MBOX_LOCK_OFS    5'h00
`define MBOX_CMD_OFS     5'h04
`define MBOX_DLEN_OFS    5'h08
`define MBOX_DATAIN_OFS  5'h0C
`define MBOX_DATAOUT_OFS 5'h10
`define MBOX_EXECUTE_OFS 5'h14
`define MBOX_STATUS_OFS  5'h18
`define MBOX_UNLOCK_OFS  5'h1C

`endif

/* design/mbox_fsm.sv */
// mailbox protocol FSM with lock ownership, requester checks, pointer control and notifications
`timescale 1ns/1ps

module mbox_fsm (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       req_soc,
    input  logic                       lock_rd,
    input  logic                       cmd_wr,
    input  logic                       dlen_wr,
    input  logic                       datain_wr,
    input  logic                       dataout_rd,
    input  logic                       unlock_wr,
    input  logic                       lock,
    input  logic                       execute,
    input  mbox_pkg::mbox_cmd_status_e cmd_status,
    output mbox_pkg::mbox_state_e      state,
    output logic                       soc_has_lock,
    output logic                       valid_requester,
    output logic                       valid_receiver,
    output logic                       lock_set,
    output logic                       release_lock,
    output logic                       force_clr,
    output logic                       inc_wrptr,
    output logic                       inc_rdptr,
    output logic                       rst_ptrs,
    output logic                       latch_len,
    output logic                       uc_data_avail,
    output logic                       soc_data_avail,
    output logic                       soc_req_lock
);
    import mbox_pkg::*;

    mbox_state_e state_nxt;
    logic        in_exec_uc;
    logic        in_exec_soc;
    logic        take_lock;
    logic        force_unlock;
    logic        to_exec;
    logic        to_idle;

    assign in_exec_uc  = (state == MBOX_EXECUTE_UC);
    assign in_exec_soc = (state == MBOX_EXECUTE_SOC);

    // the owner may program the mailbox, and the uC may also answer while the message is with it
    assign valid_requester = lock & ((~req_soc & (~soc_has_lock | in_exec_uc)) |
                                     (req_soc & soc_has_lock));

    // the side without the lock receives, and the owner reads the reply once it is handed back
    assign valid_receiver = lock & ((req_soc ^ soc_has_lock) |
                                    (valid_requester & ((soc_has_lock & in_exec_soc) |
                                                        (~soc_has_lock & in_exec_uc))));

    // reading the lock while it is free grants it to whoever read
    assign take_lock    = (state == MBOX_IDLE) & ~lock & lock_rd;
    assign force_unlock = unlock_wr & (state != MBOX_IDLE);

    always_comb begin
        state_nxt = state;
        inc_wrptr = 1'b0;
        inc_rdptr = 1'b0;
        to_exec   = 1'b0;
        to_idle   = 1'b0;
        case (state)
            MBOX_IDLE: begin
                if (take_lock) begin
                    state_nxt = MBOX_RDY_FOR_CMD;
                end
            end
            MBOX_RDY_FOR_CMD: begin
                if (cmd_wr & valid_requester) begin
                    state_nxt = MBOX_RDY_FOR_DLEN;
                end
            end
            MBOX_RDY_FOR_DLEN: begin
                if (dlen_wr & valid_requester) begin
                    state_nxt = MBOX_RDY_FOR_DATA;
                end
            end
            MBOX_RDY_FOR_DATA: begin
                inc_wrptr = datain_wr & valid_requester;
                // the message goes to whichever side does not hold the lock
                if (execute) begin
                    state_nxt = soc_has_lock ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
                    to_exec   = 1'b1;
                end
            end
            MBOX_EXECUTE_UC: begin
                // only the uC reads the message here and only the uC writes its response
                inc_wrptr = datain_wr & ~req_soc;
                inc_rdptr = dataout_rd & ~req_soc & valid_receiver;
                if (!execute) begin
                    state_nxt = MBOX_IDLE;
                    to_idle   = 1'b1;
                end else if (soc_has_lock & (cmd_status != CMD_BUSY)) begin
                    state_nxt = MBOX_EXECUTE_SOC;
                    to_exec   = 1'b1;
                end
            end
            MBOX_EXECUTE_SOC: begin
                inc_wrptr = datain_wr & req_soc;
                inc_rdptr = dataout_rd & req_soc & valid_receiver;
                if (!execute) begin
                    state_nxt = MBOX_IDLE;
                    to_idle   = 1'b1;
                end
            end
            default: begin
                state_nxt = MBOX_IDLE;
            end
        endcase
        // force unlock from the uC wins over any other arc
        if (force_unlock) begin
            state_nxt = MBOX_IDLE;
            to_exec   = 1'b0;
            to_idle   = 1'b1;
        end
    end

    assign lock_set     = take_lock;
    assign release_lock = to_idle;
    assign force_clr    = force_unlock;
    // pointers restart on every hand-off and release, and a hand-off also captures the length
    assign rst_ptrs     = to_exec | to_idle;
    assign latch_len    = to_exec;

    assign uc_data_avail  = in_exec_uc;
    assign soc_data_avail = in_exec_soc;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state        <= MBOX_IDLE;
            soc_has_lock <= 1'b0;
            soc_req_lock <= 1'b0;
        end else begin
            state <= state_nxt;
            if (take_lock) begin
                soc_has_lock <= req_soc;
            end else if (!lock) begin
                soc_has_lock <= 1'b0;
            end
            // pulses with the read response when the side without the lock asks for it
            soc_req_lock <= lock & lock_rd & (req_soc ^ soc_has_lock);
        end
    end

endmodule

/* design/mbox_mem.sv */
// mailbox word array with one write port and one registered read port
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_mem (
    input  logic                 clk,
    input  logic                 wr_en,
    input  mbox_pkg::mbox_ptr_t  wr_addr,
    input  mbox_pkg::mbox_data_t wr_data,
    input  logic                 rd_en,
    input  mbox_pkg::mbox_ptr_t  rd_addr,
    output mbox_pkg::mbox_data_t rd_data
);
    import mbox_pkg::*;

    mbox_data_t mem [`MBOX_DEPTH];

    // rd_data holds its word until the next enabled read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* design/mbox_pkg.sv */
// mailbox word, offset, pointer and length types with the protocol and command status enums
`include "mbox_cfg.svh"

package mbox_pkg;

    typedef logic [`MBOX_DATA_W-1:0] mbox_data_t;
    typedef logic [`MBOX_ADDR_W-1:0] mbox_addr_t;
    typedef logic [`MBOX_PTR_W-1:0]  mbox_ptr_t;
    typedef logic [`MBOX_DLEN_W-1:0] mbox_dlen_t;

    // protocol state, also reported in status bits 8:6
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_state_e;

    // the receiver moves status away from busy to hand the mailbox back
    typedef enum logic [3:0] {
        CMD_BUSY     = 4'd0,
        DATA_READY   = 4'd1,
        CMD_COMPLETE = 4'd2,
        CMD_FAILURE  = 4'd3
    } mbox_cmd_status_e;

endpackage

/* design/mbox_ptrs.sv */
// mailbox write and read pointers with the latched last valid word index
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_ptrs (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 inc_wrptr,
    input  logic                 inc_rdptr,
    input  logic                 rst_ptrs,
    input  logic                 latch_len,
    input  mbox_pkg::mbox_dlen_t dlen,
    output logic                 wr_en,
    output mbox_pkg::mbox_ptr_t  wr_addr,
    output logic                 rd_en,
    output mbox_pkg::mbox_ptr_t  rd_addr,
    output logic                 past_len
);
    import mbox_pkg::*;

    localparam mbox_ptr_t PTR_MAX = mbox_ptr_t'(`MBOX_DEPTH - 1);

    mbox_ptr_t  wrptr;
    mbox_ptr_t  rdptr;
    mbox_ptr_t  last_idx;
    mbox_dlen_t dlen_words;
    mbox_dlen_t fill_words;
    logic       rd_ok;

    // byte length rounded up to whole words
    assign dlen_words = (dlen >> 2) + mbox_dlen_t'(|dlen[1:0]);
    // a sender that wrote fewer words than it declared limits what the receiver sees
    assign fill_words = (mbox_dlen_t'(wrptr) < dlen_words) ? mbox_dlen_t'(wrptr) : dlen_words;
    assign rd_ok      = (rdptr <= last_idx);

    assign wr_en   = inc_wrptr;
    assign wr_addr = wrptr;
    // a pointer reset fetches word 0 so dataout is preloaded for the receiver
    assign rd_en   = rst_ptrs | (inc_rdptr & rd_ok);
    assign rd_addr = rst_ptrs ? '0 : rdptr;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wrptr    <= '0;
            rdptr    <= '0;
            last_idx <= '0;
            past_len <= 1'b0;
        end else begin
            if (rst_ptrs) begin
                wrptr <= '0;
            end else if (inc_wrptr & (wrptr < PTR_MAX)) begin
                wrptr <= wrptr + 1'b1;
            end
            // read pointer rests one past the last index, and the next read there is past the end
            if (rst_ptrs) begin
                rdptr    <= mbox_ptr_t'(1);
                past_len <= 1'b0;
            end else if (inc_rdptr) begin
                if (!rd_ok) begin
                    past_len <= 1'b1;
                end else if (rdptr < PTR_MAX) begin
                    rdptr <= rdptr + 1'b1;
                end
            end
            if (latch_len) begin
                last_idx <= (fill_words == '0) ? '0 : mbox_ptr_t'(fill_words - 1'b1);
            end
        end
    end

endmodule

/* design/mbox_regs.sv */
// mailbox register file with offset decode, read mux, dataout masking and response timing
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_regs (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       req_valid,
    input  logic                       req_write,
    input  logic                       req_soc,
    input  mbox_pkg::mbox_addr_t       req_addr,
    input  mbox_pkg::mbox_data_t       req_wdata,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output mbox_pkg::mbox_data_t       rsp_rdata,
    output logic                       rsp_error,
    input  mbox_pkg::mbox_state_e      state,
    input  logic                       soc_has_lock,
    input  logic                       valid_requester,
    input  logic                       valid_receiver,
    input  logic                       lock_set,
    input  logic                       release_lock,
    input  logic                       force_clr,
    input  logic                       past_len,
    input  mbox_pkg::mbox_data_t       rd_data,
    output logic                       lock_rd,
    output logic                       cmd_wr,
    output logic                       dlen_wr,
    output logic                       datain_wr,
    output logic                       dataout_rd,
    output logic                       unlock_wr,
    output logic                       lock,
    output logic                       execute,
    output mbox_pkg::mbox_cmd_status_e cmd_status,
    output mbox_pkg::mbox_data_t       cmd,
    output mbox_pkg::mbox_dlen_t       dlen,
    output mbox_pkg::mbox_data_t       datain_word
);
    import mbox_pkg::*;

    logic       acc_wr;
    logic       acc_rd;
    mbox_data_t dataout;
    mbox_data_t rd_mux;
    logic       rd_err;

    assign acc_wr = req_valid & req_ready & req_write;
    assign acc_rd = req_valid & req_ready & ~req_write;

    // raw strobes, the FSM qualifies them against the requester checks
    assign lock_rd    = acc_rd & (req_addr == `MBOX_LOCK_OFS);
    assign cmd_wr     = acc_wr & (req_addr == `MBOX_CMD_OFS);
    assign dlen_wr    = acc_wr & (req_addr == `MBOX_DLEN_OFS);
    assign datain_wr  = acc_wr & (req_addr == `MBOX_DATAIN_OFS);
    assign dataout_rd = acc_rd & (req_addr == `MBOX_DATAOUT_OFS);
    // only the uC can force the mailbox free
    assign unlock_wr  = acc_wr & (req_addr == `MBOX_UNLOCK_OFS) & ~req_soc & req_wdata[0];

    // datain goes straight into the array at the write pointer
    assign datain_word = req_wdata;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock       <= 1'b0;
            execute    <= 1'b0;
            cmd_status <= CMD_BUSY;
            cmd        <= '0;
            dlen       <= '0;
        end else begin
            if (lock_set) begin
                lock <= 1'b1;
            end else if (release_lock) begin
                lock <= 1'b0;
            end
            if (cmd_wr & valid_requester) begin
                cmd <= req_wdata;
            end
            if (dlen_wr & valid_requester) begin
                dlen <= req_wdata[`MBOX_DLEN_W-1:0];
            end
            if (force_clr) begin
                execute <= 1'b0;
            end else if (acc_wr & (req_addr == `MBOX_EXECUTE_OFS) & valid_requester) begin
                execute <= req_wdata[0];
            end
            // status goes back to busy whenever the mailbox is released
            if (release_lock) begin
                cmd_status <= CMD_BUSY;
            end else if (acc_wr & (req_addr == `MBOX_STATUS_OFS) & valid_requester) begin
                cmd_status <= mbox_cmd_status_e'(req_wdata[3:0]);
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        rd_err = 1'b0;
        case (req_addr)
            `MBOX_LOCK_OFS:    rd_mux = {{(`MBOX_DATA_W-1){1'b0}}, lock};
            `MBOX_CMD_OFS:     rd_mux = cmd;
            `MBOX_DLEN_OFS:    rd_mux = {{(`MBOX_DATA_W-`MBOX_DLEN_W){1'b0}}, dlen};
            `MBOX_EXECUTE_OFS: rd_mux = {{(`MBOX_DATA_W-1){1'b0}}, execute};
            // owner flag in bit 9 above the state, command status in the low nibble
            `MBOX_STATUS_OFS:  rd_mux = {{(`MBOX_DATA_W-10){1'b0}}, soc_has_lock, state,
                                        2'b00, cmd_status};
            `MBOX_DATAIN_OFS, `MBOX_UNLOCK_OFS: rd_mux = '0;
            `MBOX_DATAOUT_OFS: begin
                // zero for a wrong receiver or once the message has been read out
                rd_err = ~valid_receiver;
                if (valid_receiver & ~past_len) begin
                    rd_mux = dataout;
                end
            end
            default: rd_err = 1'b1;
        endcase
    end

    // one read in flight, so ready drops for the cycle after each accepted read
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_error <= 1'b0;
        end else begin
            req_ready <= ~acc_rd;
            rsp_valid <= acc_rd;
            rsp_error <= acc_rd & rd_err;
        end
    end

    // dataout follows the array read port one cycle later
    always_ff @(posedge clk) begin
        dataout <= rd_data;
        if (acc_rd) begin
            rsp_rdata <= rd_mux;
        end
    end

endmodule

/* design/mbox_top.sv */
// mailbox top level joining the protocol FSM, register file, pointers and word array
`timescale 1ns/1ps

module mbox_top (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic                 req_soc,
    input  mbox_pkg::mbox_addr_t req_addr,
    input  mbox_pkg::mbox_data_t req_wdata,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic                 rsp_error,
    output mbox_pkg::mbox_data_t rsp_rdata,
    output logic                 uc_data_avail,
    output logic                 soc_data_avail,
    output logic                 soc_req_lock
);
    import mbox_pkg::*;

    // FSM and register handshake
    mbox_state_e      state;
    mbox_cmd_status_e cmd_status;
    logic             soc_has_lock;
    logic             valid_requester;
    logic             valid_receiver;
    logic             lock_set;
    logic             release_lock;
    logic             force_clr;
    logic             lock;
    logic             execute;
    logic             lock_rd;
    logic             cmd_wr;
    logic             dlen_wr;
    logic             datain_wr;
    logic             dataout_rd;
    logic             unlock_wr;

    // pointer control and array access
    logic             inc_wrptr;
    logic             inc_rdptr;
    logic             rst_ptrs;
    logic             latch_len;
    logic             past_len;
    logic             wr_en;
    logic             rd_en;
    mbox_ptr_t        wr_addr;
    mbox_ptr_t        rd_addr;
    mbox_dlen_t       dlen;
    mbox_data_t       datain_word;
    mbox_data_t       rd_data;

    mbox_fsm fsm_i (.*);

    // the command value is only read back through the register port
    mbox_regs regs_i (
        .*,
        .cmd ()
    );

    mbox_ptrs ptrs_i (.*);

    mbox_mem mem_i (
        .*,
        .wr_data (datain_word)
    );

endmodule

/* filelist.f */
+incdir+design
design/mbox_pkg.sv
design/mbox_fsm.sv
design/mbox_regs.sv
design/mbox_ptrs.sv
design/mbox_mem.sv
design/mbox_top.sv
bench/mbox_tb.sv
